//--- spiMem_trace.txt
# op addr data expect in hex
# W write, R read, A write dropped after 12 bits, expect checked on R only
R 00 00 00
W 05 a5 00
R 05 00 a5
W 00 3c 00
W 7f c3 00
W 40 81 00
W 01 7e 00
R 7f 00 c3
R 00 00 3c
R 40 00 81
R 01 00 7e
A 05 ff 00
R 05 00 a5
A 22 55 00
R 22 00 00
W 7f 5a 00
R 7f 00 5a
R 00 00 3c
W 2a 96 00
W 55 69 00
R 55 00 69
R 2a 00 96
R 05 ff a5

//--- vlog.f
+incdir+.
spiMemPkg.sv
spiPinSync.sv
spiShiftReg.sv
spiControl.sv
memArray.sv
spiMemTop.sv
tbSpiMem.sv

//--- Makefile
# Verilator build for the SPI byte memory testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tbSpiMem
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
EXTRA     ?=

SRCS := $(filter %.sv,$(shell cat $(FLIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS) spiMem_defines.svh
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulator is the test result
run: $(SIM) spiMem_trace.txt
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tbSpiMem.sv
`timescale 1ns/10ps
`include "spiMem_defines.svh"

module tbSpiMem;
  import spiMemPkg::*;

  localparam int    spiHalfClks = 4;  // sclk half-period in clk cycles
  localparam int    memDepth    = 1 << `SPI_ADDR_W;
  localparam string traceFile   = "spiMem_trace.txt";

  logic clk;
  logic rstN;
  logic sclk;
  logic csN;
  logic mosi;
  logic miso;
  logic misoEn;

  spiByte_t    model [memDepth];  // expected memory contents
  logic [31:0] rngState;

  spiMemTop i_dut (
    .clk    (clk),
    .rstN   (rstN),
    .sclk   (sclk),
    .csN    (csN),
    .mosi   (mosi),
    .miso   (miso),
    .misoEn (misoEn)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // n rising edges, then 1 ns so pins move clear of the edge
  task automatic waitClocks(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkByte(input string name, input spiByte_t expV, input spiByte_t actV);
    if (actV !== expV) begin
      abortRun($sformatf("** Error: %s expected 0x%02h actual 0x%02h", name, expV, actV));
    end
  endtask

  task automatic checkLevel(input string name, input logic expV, input logic actV);
    if (actV !== expV) begin
      abortRun($sformatf("** Error: %s expected %b actual %b", name, expV, actV));
    end
  endtask

  // poll misoEn once per cycle, give up after limit cycles
  task automatic waitMisoEn(input logic want, input int limit, input string what);
    int n;
    n = 0;
    while (misoEn !== want) begin
      if (n == limit) begin
        abortRun(what);
      end
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  // drops the rest of a comment line
  task automatic skipRestOfLine(input int fd);
    int ch;
    ch = 0;
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  // one mode 0 frame as master
  // A frames stop after 12 bits and raise csN mid-byte
  task automatic runFrame(input logic [7:0] op, input spiAddr_t addr, input spiByte_t data,
                          input spiByte_t expV, input int lineNo);
    logic [15:0] frame;
    logic        isRead;
    logic        expEn;
    spiByte_t    got;
    int          nBits;
    string       tag;
    isRead = (op == "R");
    frame  = {addr, isRead, data};  // addr MSB first, r/w, then data
    nBits  = (op == "A") ? 12 : 16;
    tag    = $sformatf("line %0d %c 0x%02h", lineNo, op, addr);
    got    = '0;
    csN    = 1'b0;
    for (int i = 0; i < nBits; i++) begin
      mosi = frame[15-i];  // changes with the falling sclk
      if (isRead && i == 8) begin
        // read byte loads during this low phase
        waitMisoEn(1'b1, spiHalfClks, $sformatf("%s misoEn never rose for the data phase", tag));
      end
      waitClocks(spiHalfClks);
      expEn = isRead && (i >= 8);
      checkLevel($sformatf("%s misoEn at bit %0d", tag, i), expEn, misoEn);
      if (expEn) begin
        got = {got[`SPI_DATA_W-2:0], miso};  // sampled as sclk rises
      end
      sclk = 1'b1;
      waitClocks(spiHalfClks);
      sclk = 1'b0;
    end
    waitClocks(spiHalfClks);
    csN = 1'b1;
    waitMisoEn(1'b0, 4, $sformatf("%s misoEn still high 4 cycles after csN rose", tag));
    if (isRead) begin
      checkByte($sformatf("%s read data", tag), expV, got);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          lineNo;
    int          txCount;
    int          gap;
    logic [7:0]  op;
    logic [7:0]  addrV;
    logic [7:0]  dataV;
    logic [7:0]  expV;
    rstN     = 1'b0;
    sclk     = 1'b0;
    csN      = 1'b1;
    mosi     = 1'b0;
    rngState = 32'd12;
    lineNo   = 0;
    txCount  = 0;
    for (int i = 0; i < memDepth; i++) begin
      model[i] = '0;  // memory powers up cleared
    end
    waitClocks(4);
    rstN = 1'b1;
    waitClocks(2);
    checkLevel("misoEn after reset", 1'b0, misoEn);

    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
      abortRun("cannot open trace file spiMem_trace.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) break;  // end of file
      lineNo++;
      if (op == "#") begin
        skipRestOfLine(fd);
        continue;
      end
      code = $fscanf(fd, "%h %h %h", addrV, dataV, expV);
      if (code != 3) begin
        abortRun($sformatf("trace line %0d does not hold address, data and expect", lineNo));
      end
      if (op != "W" && op != "R" && op != "A") begin
        abortRun($sformatf("trace line %0d has unknown op %c", lineNo, op));
      end
      if (addrV[7]) begin
        abortRun($sformatf("trace line %0d address 0x%02h is past the memory", lineNo, addrV));
      end
      // trace has to agree with what earlier lines wrote
      if (op == "R" && model[addrV[6:0]] !== expV) begin
        abortRun($sformatf("trace line %0d expects 0x%02h at 0x%02h but earlier lines leave 0x%02h",
                           lineNo, expV, addrV, model[addrV[6:0]]));
      end
      runFrame(op, addrV[6:0], dataV, expV, lineNo);
      if (op == "W") begin
        model[addrV[6:0]] = dataV;
      end
      txCount++;
      rngState = xorshift32(rngState);
      gap = 2 + int'(rngState[2:0]);  // 2 to 9 idle cycles
      waitClocks(gap);
    end
    $fclose(fd);

    if (txCount == 0) begin
      abortRun("trace file held no transactions");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- spiMemTop.sv
`timescale 1ns/10ps
`include "spiMem_defines.svh"

module spiMemTop (
  input  logic clk,
  input  logic rstN,
  input  logic sclk,    // from master, async to clk
  input  logic csN,
  input  logic mosi,
  output logic miso,
  output logic misoEn   // pad enable, kept separate from miso
);
  import spiMemPkg::*;

  spiEvt_t  pinEvt;   // conditioned pins
  logic     srLoad;   // read byte into shift register
  memReq_t  memReq;
  spiByte_t rdData;   // memory read register
  spiByte_t srData;   // shift register contents

  // pins into the clk domain
  spiPinSync uPinSync (
    .clk    (clk),
    .rstN   (rstN),
    .sclk   (sclk),
    .csN    (csN),
    .mosi   (mosi),
    .pinEvt (pinEvt)
  );

  // serial in, serial out, shared by address, write and read phases
  spiShiftReg uShiftReg (
    .clk    (clk),
    .rstN   (rstN),
    .pinEvt (pinEvt),
    .srLoad (srLoad),
    .rdData (rdData),
    .srData (srData),
    .miso   (miso)
  );

  // frame FSM
  spiControl uControl (
    .clk    (clk),
    .rstN   (rstN),
    .pinEvt (pinEvt),
    .srData (srData),
    .srLoad (srLoad),
    .memReq (memReq),
    .misoEn (misoEn)
  );

  // 128 x 8 storage
  memArray uMem (
    .clk    (clk),
    .memReq (memReq),
    .rdData (rdData)
  );

endmodule

//--- memArray.sv
`timescale 1ns/10ps
`include "spiMem_defines.svh"

module memArray (
  input  logic                clk,
  input  spiMemPkg::memReq_t  memReq,
  output spiMemPkg::spiByte_t rdData
);
  import spiMemPkg::*;

  localparam int depth = 1 << `SPI_ADDR_W;  // 128 bytes

  spiByte_t mem [depth];

  // zero contents at power up
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // write lands at the clock edge
  always_ff @(posedge clk) begin
    if (memReq.wrEn) begin
      mem[memReq.addr] <= memReq.wrData;
    end
  end

  // registered read, follows the address every cycle
  // same-cycle write returns the old byte
  always_ff @(posedge clk) begin
    rdData <= mem[memReq.addr];
  end

endmodule

//--- spiControl.sv
`timescale 1ns/10ps
`include "spiMem_defines.svh"

module spiControl (
  input  logic                clk,
  input  logic                rstN,
  input  spiMemPkg::spiEvt_t  pinEvt,
  input  spiMemPkg::spiByte_t srData,
  output logic                srLoad,
  output spiMemPkg::memReq_t  memReq,
  output logic                misoEn
);
  import spiMemPkg::*;

  // 7 address + r/w + 8 data
  localparam int frameBits = `SPI_ADDR_W + 1 + `SPI_DATA_W;
  localparam int cntW      = $clog2(frameBits + 1);

  localparam logic [cntW-1:0] addrCnt  = cntW'(`SPI_ADDR_W);  // rises before the r/w bit
  localparam logic [cntW-1:0] lastCnt  = cntW'(frameBits - 1);
  localparam logic [cntW-1:0] frameCnt = cntW'(frameBits);

  ctlState_t       state;
  logic [cntW-1:0] bitCnt;  // rises seen in this frame
  spiAddr_t        addrQ;
  logic            wrEnQ;
  logic            addrDone;
  logic            dataDone;
  logic            readDone;

  // rise counter, runs for the whole frame whatever the state
  always_ff @(posedge clk) begin
    if (!rstN || !pinEvt.csActive) begin
      bitCnt <= '0;
    end else if (pinEvt.sclkRise) begin
      bitCnt <= bitCnt + 1'b1;
    end
  end

  assign addrDone = pinEvt.sclkRise && (bitCnt == addrCnt);  // 8th rise, r/w bit
  assign dataDone = pinEvt.sclkRise && (bitCnt == lastCnt);  // 16th rise
  // master has sampled the last bit, this is the trailing fall
  assign readDone = pinEvt.sclkFall && (bitCnt == frameCnt);

  // srData still holds just the address bits in the 8th rise cycle
  always_ff @(posedge clk) begin
    if (state == ctlAddr && addrDone) begin
      addrQ <= srData[`SPI_ADDR_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN || !pinEvt.csActive) begin
      state  <= ctlIdle;  // csN rising aborts, no write
      srLoad <= 1'b0;
      wrEnQ  <= 1'b0;
      misoEn <= 1'b0;
    end else begin
      srLoad <= 1'b0;  // strobes by default
      wrEnQ  <= 1'b0;
      case (state)
        ctlIdle: begin
          // count 0 means a fresh frame, not the tail of a finished one
          if (bitCnt == '0) state <= ctlAddr;
        end
        ctlAddr: begin
          if (addrDone) state <= ctlRw;
        end
        ctlRw: begin
          if (srData[0]) begin  // 1 is read
            srLoad <= 1'b1;     // addr was stable last cycle, rdData valid now
            state  <= ctlReadLoad;
          end else begin
            state <= ctlWriteData;
          end
        end
        ctlReadLoad: begin
          misoEn <= 1'b1;
          state  <= ctlReadShift;
        end
        ctlReadShift: begin
          if (readDone) begin
            misoEn <= 1'b0;
            state  <= ctlIdle;  // waits there for csN
          end
        end
        ctlWriteData: begin
          if (dataDone) begin
            wrEnQ <= 1'b1;  // byte lands in shReg with this rise
            state <= ctlWriteCommit;
          end
        end
        ctlWriteCommit: begin
          state <= ctlIdle;
        end
        default: state <= ctlIdle;
      endcase
    end
  end

  assign memReq.addr   = addrQ;
  assign memReq.wrEn   = wrEnQ;
  assign memReq.wrData = srData;  // full data byte in the commit cycle

  wrOnlyInCommit: assert property (@(posedge clk) disable iff (!rstN)
    memReq.wrEn |-> state == ctlWriteCommit)
    else $error("memory write outside the commit state");

  noDriveDuringWrite: assert property (@(posedge clk) disable iff (!rstN)
    !(misoEn && memReq.wrEn))
    else $error("miso enabled while writing memory");

  idleAfterDeselect: assert property (@(posedge clk) disable iff (!rstN)
    !pinEvt.csActive |=> state == ctlIdle)
    else $error("controller not idle after chip select dropped");

endmodule

//--- spiShiftReg.sv
`timescale 1ns/10ps
`include "spiMem_defines.svh"

module spiShiftReg (
  input  logic                clk,
  input  logic                rstN,
  input  spiMemPkg::spiEvt_t  pinEvt,
  input  logic                srLoad,
  input  spiMemPkg::spiByte_t rdData,
  output spiMemPkg::spiByte_t srData,
  output logic                miso
);
  import spiMemPkg::*;

  localparam int msb = `SPI_DATA_W - 1;

  spiByte_t shReg;   // parallel contents
  logic     misoQ;   // registered miso bit

  // mode 0
  //   mosi is taken on rising sclk, LSB end, so the MSB arrives first
  //   miso changes after falling sclk
  // a rise already moved the next read bit up to the MSB, so the
  // fall only has to copy it out
  always_ff @(posedge clk) begin
    if (!rstN || !pinEvt.csActive) begin
      shReg <= '0;  // every frame starts empty
      misoQ <= 1'b0;
    end else if (srLoad) begin
      shReg <= rdData;
      misoQ <= rdData[msb];  // first bit ready before the first fall
    end else if (pinEvt.sclkRise) begin
      shReg <= {shReg[msb-1:0], pinEvt.mosi};
    end else if (pinEvt.sclkFall) begin
      misoQ <= shReg[msb];
    end
  end

  assign srData = shReg;
  assign miso   = misoQ;

  // load happens between edges, never on top of one
  loadBetweenEdges: assert property (@(posedge clk) disable iff (!rstN)
    srLoad |-> !(pinEvt.sclkRise || pinEvt.sclkFall))
    else $error("read load collides with an sclk edge, sclk too fast");

endmodule

//--- spiPinSync.sv
`timescale 1ns/10ps
`include "spiMem_defines.svh"

module spiPinSync (
  input  logic               clk,
  input  logic               rstN,
  input  logic               sclk,
  input  logic               csN,
  input  logic               mosi,
  output spiMemPkg::spiEvt_t pinEvt
);
  import spiMemPkg::*;

  localparam int syncStages = `SPI_SYNC_STAGES;

  logic [syncStages-1:0] sclkSync;  // MSB is the stable end
  logic [syncStages-1:0] csNSync;
  logic [syncStages-1:0] mosiSync;
  logic                  sclkPrev;  // delayed copy for edge detect
  logic                  sclkS;
  spiEvt_t               evtNext;

  // plain flop chains, new sample enters at bit 0
  always_ff @(posedge clk) begin
    if (!rstN) begin
      sclkSync <= '0;
      csNSync  <= '1;  // deselected until the pin says otherwise
      mosiSync <= '0;
    end else begin
      sclkSync <= {sclkSync[syncStages-2:0], sclk};
      csNSync  <= {csNSync[syncStages-2:0], csN};
      mosiSync <= {mosiSync[syncStages-2:0], mosi};
    end
  end

  assign sclkS = sclkSync[syncStages-1];

  always_comb begin
    evtNext.sclkRise = sclkS & ~sclkPrev;
    evtNext.sclkFall = ~sclkS & sclkPrev;
    evtNext.csActive = ~csNSync[syncStages-1];  // active low pin
    evtNext.mosi     = mosiSync[syncStages-1];
  end

  // edge register, all four fields leave aligned
  // pin edge to event pulse is 3 clk cycles
  always_ff @(posedge clk) begin
    if (!rstN) begin
      sclkPrev <= 1'b0;
      pinEvt   <= '0;
    end else begin
      sclkPrev <= sclkS;
      pinEvt   <= evtNext;
    end
  end

  // a real edge is one direction only
  sclkEdgeOneHot: assert property (@(posedge clk) disable iff (!rstN)
    !(pinEvt.sclkRise && pinEvt.sclkFall))
    else $error("sclk rise and fall pulses high in the same cycle");

endmodule

//--- spiMemPkg.sv
`include "spiMem_defines.svh"

package spiMemPkg;

  // one byte on the wire or in memory
  typedef logic [`SPI_DATA_W-1:0] spiByte_t;

  // memory address, 128 locations
  typedef logic [`SPI_ADDR_W-1:0] spiAddr_t;

  // conditioned pin events in the clk domain
  typedef struct packed {
    logic sclkRise;  // one-cycle pulse
    logic sclkFall;  // one-cycle pulse
    logic csActive;  // level, high while csN is low
    logic mosi;      // synchronized data bit
  } spiEvt_t;

  // request from controller to memory
  typedef struct packed {
    spiAddr_t addr;    // read and write address
    logic     wrEn;    // write strobe
    spiByte_t wrData;  // byte to store
  } memReq_t;

  // transaction controller states
  typedef enum logic [2:0] {
    ctlIdle,         // waiting for a new frame
    ctlAddr,         // taking address bits
    ctlRw,           // r/w bit sits in srData[0]
    ctlReadLoad,     // shift register loads the read byte
    ctlReadShift,    // byte going out on miso
    ctlWriteData,    // taking data bits
    ctlWriteCommit   // one-cycle write strobe
  } ctlState_t;

endpackage

//--- spiMem_defines.svh
`ifndef SPIMEM_DEFINES_SVH
`define SPIMEM_DEFINES_SVH

// sizing for the spi byte memory

// address bits sent by the master ahead of the r/w bit
// also sets the memory depth to 2**SPI_ADDR_W bytes
`define SPI_ADDR_W 7

// one data byte per transaction
`define SPI_DATA_W 8

// flops per pin synchronizer
// raising this adds latency to every pin event
`define SPI_SYNC_STAGES 2

// frame length in sclk rises follows from these three
//   address bits + one r/w bit + data bits
// the controller derives it locally

`endif
